// ==== include/wisc_defs.svh ====
// Opcode, ALU, flag and branch encodings plus core constants, included by the stages
`ifndef WISC_DEFS_SVH
`define WISC_DEFS_SVH

`define WISC_NUM_REGS 16
`define WISC_RESET_PC 16'h0000

`define OP_ADD 4'd0
`define OP_SUB 4'd1
`define OP_AND 4'd2
`define OP_NOR 4'd3
`define OP_SLL 4'd4
`define OP_SRL 4'd5
`define OP_SRA 4'd6
`define OP_LW  4'd8
`define OP_SW  4'd9
`define OP_LHB 4'd10
`define OP_LLB 4'd11
`define OP_B   4'd12
`define OP_HLT 4'd15

// ALU selector, low opcode bits for arithmetic and shifts
`define ALU_ADD   3'd0
`define ALU_SUB   3'd1
`define ALU_AND   3'd2
`define ALU_NOR   3'd3
`define ALU_SLL   3'd4
`define ALU_SRL   3'd5
`define ALU_SRA   3'd6
`define ALU_MERGE 3'd7 // High byte of b over low byte of a

`define FLAG_Z 2
`define FLAG_V 1
`define FLAG_N 0

`define BR_NEQ    3'd0
`define BR_EQ     3'd1
`define BR_GT     3'd2
`define BR_LT     3'd3
`define BR_GTE    3'd4
`define BR_LTE    3'd5
`define BR_OVFL   3'd6
`define BR_UNCOND 3'd7

`endif

// ==== logic/wisc_pkg.sv ====
// Shared vector types and the bus state enum, imported by the pipeline stages
`default_nettype none

package wisc_pkg;

	typedef logic [15:0] word_t;        // Data word, PC and instruction
	typedef logic [3:0]  reg_idx_t;     // Register index
	typedef logic [3:0]  opcode_t;      // Instruction bits 15..12
	typedef logic [2:0]  alu_op_t;      // ALU operation selector
	typedef logic [2:0]  branch_cond_t; // Branch condition
	typedef logic [2:0]  flags_t;       // Zero, overflow, negative

	// Memory stage bus cycle tracking
	typedef enum logic {
		idle,
		bus_wait
	} mem_state_e;

endpackage

`default_nettype wire

// ==== logic/fetch_stage.sv ====
// Fetch stage: holds the PC, drives the instruction port and the fetch/decode register
`timescale 1ns/1ps
`default_nettype none
`include "wisc_defs.svh"

module fetch_stage (
	input  wire logic            clk,
	input  wire logic            rst,
	input  wire logic            stall,
	input  wire logic            mem_busy,
	input  wire logic            halted,
	input  wire logic            branch_taken,
	input  wire wisc_pkg::word_t branch_target,
	input  wire wisc_pkg::word_t instr_dat,
	output wisc_pkg::word_t      instr_adr,
	output wisc_pkg::word_t      instr_fd,
	output wisc_pkg::word_t      pc_fd,
	output logic                 valid_fd
);
	import wisc_pkg::*;

	word_t pc;
	logic  hold;
	logic  advance;

	assign hold    = halted || mem_busy; // Whole front end frozen
	assign advance = !hold && !branch_taken && !stall;
	assign instr_adr = pc;

	always_ff @(posedge clk) begin
		if (rst) begin
			pc       <= `WISC_RESET_PC;
			valid_fd <= 1'b0;
		end else if (!hold) begin
			if (branch_taken) begin
				pc       <= branch_target;
				valid_fd <= 1'b0; // Wrong-path fetch dropped
			end else if (!stall) begin
				pc       <= pc + 16'd1;
				valid_fd <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (advance) begin
			instr_fd <= instr_dat;
			pc_fd    <= pc;
		end
	end

endmodule

`default_nettype wire

// ==== logic/reg_file.sv ====
// Sixteen-entry register file with r0 tied to zero and same-cycle write-through reads
`timescale 1ns/1ps
`default_nettype none
`include "wisc_defs.svh"

module reg_file (
	input  wire logic                clk,
	input  wire logic                rst,
	input  wire wisc_pkg::reg_idx_t  rs_a,
	input  wire wisc_pkg::reg_idx_t  rs_b,
	input  wire logic                wr_en,
	input  wire wisc_pkg::reg_idx_t  wr_idx,
	input  wire wisc_pkg::word_t     wr_data,
	output wisc_pkg::word_t          rd_a,
	output wisc_pkg::word_t          rd_b
);
	import wisc_pkg::*;

	word_t regs [`WISC_NUM_REGS];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `WISC_NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en && wr_idx != '0) begin
			regs[wr_idx] <= wr_data;
		end
	end

	// Writeback in the same cycle is visible to decode
	assign rd_a = (rs_a == '0) ? '0 : (wr_en && wr_idx == rs_a) ? wr_data : regs[rs_a];
	assign rd_b = (rs_b == '0) ? '0 : (wr_en && wr_idx == rs_b) ? wr_data : regs[rs_b];

endmodule

`default_nettype wire

// ==== logic/decode_stage.sv ====
// Decode stage: control decode, RAW hazard stall and the decode/execute register
`timescale 1ns/1ps
`default_nettype none
`include "wisc_defs.svh"

module decode_stage (
	input  wire logic                   clk,
	input  wire logic                   rst,
	input  wire wisc_pkg::word_t        instr_fd,
	input  wire wisc_pkg::word_t        pc_fd,
	input  wire logic                   valid_fd,
	input  wire logic                   branch_taken,
	input  wire logic                   mem_busy,
	input  wire wisc_pkg::reg_idx_t     dst_ex,
	input  wire wisc_pkg::reg_idx_t     dst_mem,
	input  wire wisc_pkg::reg_idx_t     dst_wb,
	input  wire logic                   wr_ex,
	input  wire logic                   wr_mem,
	input  wire logic                   wr_wb,
	input  wire wisc_pkg::word_t        rd_a,
	input  wire wisc_pkg::word_t        rd_b,
	output logic                        stall,
	output wisc_pkg::reg_idx_t          rs_a,
	output wisc_pkg::reg_idx_t          rs_b,
	output wisc_pkg::alu_op_t           alu_op_de,
	output wisc_pkg::word_t             op_a_de,
	output wisc_pkg::word_t             op_b_de,
	output wisc_pkg::word_t             store_data_de,
	output wisc_pkg::word_t             pc_de,
	output wisc_pkg::word_t             imm_de,
	output wisc_pkg::reg_idx_t          dst_de,
	output logic                        reg_wr_de,
	output logic                        mem_rd_de,
	output logic                        mem_wr_de,
	output logic                        branch_de,
	output logic                        halt_de,
	output logic                        valid_de,
	output wisc_pkg::branch_cond_t      cond_de
);
	import wisc_pkg::*;

	opcode_t op;
	alu_op_t alu_op;
	word_t   imm;
	logic    use_a;
	logic    use_b;
	logic    imm_a;
	logic    imm_b;
	logic    reg_wr;
	logic    mem_rd;
	logic    mem_wr;
	logic    is_branch;
	logic    is_halt;
	logic    hz_ex;
	logic    hz_mem;
	logic    hz_wb;

	function automatic logic src_hit(input reg_idx_t dst, input logic wr,
		input reg_idx_t a, input reg_idx_t b, input logic ua, input logic ub);
		return wr && ((ua && dst == a) || (ub && dst == b));
	endfunction

	assign op   = instr_fd[15:12];
	assign rs_a = (op == `OP_LHB) ? instr_fd[11:8] : instr_fd[7:4]; // LHB keeps rt low byte
	assign rs_b = (op == `OP_SW) ? instr_fd[11:8] : instr_fd[3:0];  // SW data register

	always_comb begin
		alu_op    = `ALU_ADD;
		imm       = {{12{instr_fd[3]}}, instr_fd[3:0]}; // Load/store offset
		use_a     = 1'b0;
		use_b     = 1'b0;
		imm_a     = 1'b0;
		imm_b     = 1'b0;
		reg_wr    = 1'b0;
		mem_rd    = 1'b0;
		mem_wr    = 1'b0;
		is_branch = 1'b0;
		is_halt   = 1'b0;
		case (op)
			`OP_ADD, `OP_SUB, `OP_AND, `OP_NOR: begin
				alu_op = alu_op_t'(op[2:0]);
				use_a  = 1'b1;
				use_b  = 1'b1;
				reg_wr = 1'b1;
			end
			`OP_SLL, `OP_SRL, `OP_SRA: begin
				alu_op = alu_op_t'(op[2:0]);
				imm    = {12'd0, instr_fd[3:0]}; // Shift amount
				use_a  = 1'b1;
				imm_b  = 1'b1;
				reg_wr = 1'b1;
			end
			`OP_LW: begin
				use_a  = 1'b1;
				imm_b  = 1'b1;
				reg_wr = 1'b1;
				mem_rd = 1'b1;
			end
			`OP_SW: begin
				use_a  = 1'b1;
				use_b  = 1'b1;
				imm_b  = 1'b1;
				mem_wr = 1'b1;
			end
			`OP_LHB: begin
				alu_op = `ALU_MERGE;
				imm    = {instr_fd[7:0], 8'd0};
				use_a  = 1'b1;
				imm_b  = 1'b1;
				reg_wr = 1'b1;
			end
			`OP_LLB: begin
				alu_op = `ALU_MERGE; // Sign byte over immediate byte
				imm    = {{8{instr_fd[7]}}, instr_fd[7:0]};
				imm_a  = 1'b1;
				imm_b  = 1'b1;
				reg_wr = 1'b1;
			end
			`OP_B: begin
				imm       = {{7{instr_fd[8]}}, instr_fd[8:0]};
				is_branch = 1'b1;
			end
			`OP_HLT: is_halt = 1'b1;
			default: ;
		endcase
	end

	assign hz_ex  = src_hit(dst_ex, wr_ex, rs_a, rs_b, use_a, use_b);
	assign hz_mem = src_hit(dst_mem, wr_mem, rs_a, rs_b, use_a, use_b);
	assign hz_wb  = src_hit(dst_wb, wr_wb, rs_a, rs_b, use_a, use_b);

	// Writeback only blocks while the bus holds off its register write
	assign stall = valid_fd && (hz_ex || hz_mem || (hz_wb && mem_busy));

	always_ff @(posedge clk) begin
		if (rst) begin
			valid_de <= 1'b0;
		end else if (!mem_busy) begin
			valid_de <= valid_fd && !stall && !branch_taken; // Bubble on stall or flush
		end
	end

	always_ff @(posedge clk) begin
		if (!mem_busy) begin
			alu_op_de     <= alu_op;
			op_a_de       <= imm_a ? imm : rd_a;
			op_b_de       <= imm_b ? imm : rd_b;
			store_data_de <= rd_b;
			pc_de         <= pc_fd;
			imm_de        <= imm;
			dst_de        <= instr_fd[11:8];
			cond_de       <= instr_fd[11:9];
			reg_wr_de     <= reg_wr;
			mem_rd_de     <= mem_rd;
			mem_wr_de     <= mem_wr;
			branch_de     <= is_branch;
			halt_de       <= is_halt;
		end
	end

endmodule

`default_nettype wire

// ==== logic/execute_stage.sv ====
// Execute stage: saturating ALU, flag register, branch resolution and execute/memory register
`timescale 1ns/1ps
`default_nettype none
`include "wisc_defs.svh"

module execute_stage (
	input  wire logic                   clk,
	input  wire logic                   rst,
	input  wire logic                   mem_busy,
	input  wire wisc_pkg::alu_op_t      alu_op_de,
	input  wire wisc_pkg::word_t        op_a_de,
	input  wire wisc_pkg::word_t        op_b_de,
	input  wire wisc_pkg::word_t        store_data_de,
	input  wire wisc_pkg::word_t        pc_de,
	input  wire wisc_pkg::word_t        imm_de,
	input  wire wisc_pkg::reg_idx_t     dst_de,
	input  wire logic                   reg_wr_de,
	input  wire logic                   mem_rd_de,
	input  wire logic                   mem_wr_de,
	input  wire logic                   branch_de,
	input  wire logic                   halt_de,
	input  wire logic                   valid_de,
	input  wire wisc_pkg::branch_cond_t cond_de,
	output logic                        branch_taken,
	output wisc_pkg::word_t             branch_target,
	output wisc_pkg::reg_idx_t          dst_ex,
	output logic                        wr_ex,
	output wisc_pkg::word_t             result_em,
	output wisc_pkg::word_t             store_data_em,
	output wisc_pkg::reg_idx_t          dst_em,
	output logic                        reg_wr_em,
	output logic                        mem_rd_em,
	output logic                        mem_wr_em,
	output logic                        halt_em,
	output logic                        valid_em
);
	import wisc_pkg::*;

	word_t  sum;
	word_t  diff;
	word_t  raw;
	word_t  result;
	logic   ovf;
	logic   add_sub;
	logic   flag_en;
	logic   cond_true;
	flags_t flags_q;

	always_comb begin
		sum  = op_a_de + op_b_de;
		diff = op_a_de - op_b_de;
		ovf  = 1'b0;
		case (alu_op_de)
			`ALU_ADD: begin
				raw = sum;
				ovf = (op_a_de[15] == op_b_de[15]) && (sum[15] != op_a_de[15]);
			end
			`ALU_SUB: begin
				raw = diff;
				ovf = (op_a_de[15] != op_b_de[15]) && (diff[15] != op_a_de[15]);
			end
			`ALU_AND: raw = op_a_de & op_b_de;
			`ALU_NOR: raw = ~(op_a_de | op_b_de);
			`ALU_SLL: raw = op_a_de << op_b_de[3:0];
			`ALU_SRL: raw = op_a_de >> op_b_de[3:0];
			`ALU_SRA: raw = $signed(op_a_de) >>> op_b_de[3:0];
			default:  raw = {op_b_de[15:8], op_a_de[7:0]}; // LLB and LHB byte merge
		endcase
		result = ovf ? (op_a_de[15] ? 16'h8000 : 16'h7fff) : raw; // Saturate toward sign of a
	end

	assign add_sub = (alu_op_de == `ALU_ADD) || (alu_op_de == `ALU_SUB);
	assign flag_en = valid_de && reg_wr_de && !mem_rd_de &&
		(add_sub || alu_op_de == `ALU_AND || alu_op_de == `ALU_NOR); // Register ALU ops only

	always_ff @(posedge clk) begin
		if (rst) begin
			flags_q <= '0;
		end else if (flag_en && !mem_busy) begin
			flags_q[`FLAG_Z] <= (result == '0);
			if (add_sub) begin
				flags_q[`FLAG_V] <= ovf;
				flags_q[`FLAG_N] <= result[15];
			end
		end
	end

	always_comb begin
		case (cond_de)
			`BR_NEQ:  cond_true = !flags_q[`FLAG_Z];
			`BR_EQ:   cond_true = flags_q[`FLAG_Z];
			`BR_GT:   cond_true = !flags_q[`FLAG_Z] && !flags_q[`FLAG_N];
			`BR_LT:   cond_true = flags_q[`FLAG_N];
			`BR_GTE:  cond_true = flags_q[`FLAG_Z] || !flags_q[`FLAG_N];
			`BR_LTE:  cond_true = flags_q[`FLAG_Z] || flags_q[`FLAG_N];
			`BR_OVFL: cond_true = flags_q[`FLAG_V];
			default:  cond_true = 1'b1;
		endcase
	end

	assign branch_taken  = valid_de && branch_de && cond_true;
	assign branch_target = pc_de + 16'd1 + imm_de;
	assign dst_ex = dst_de;
	assign wr_ex  = valid_de && reg_wr_de;

	always_ff @(posedge clk) begin
		if (rst) begin
			valid_em <= 1'b0;
		end else if (!mem_busy) begin
			valid_em <= valid_de;
		end
	end

	always_ff @(posedge clk) begin
		if (!mem_busy) begin
			result_em     <= result; // Address for loads and stores
			store_data_em <= store_data_de;
			dst_em        <= dst_de;
			reg_wr_em     <= reg_wr_de;
			mem_rd_em     <= mem_rd_de;
			mem_wr_em     <= mem_wr_de;
			halt_em       <= halt_de;
		end
	end

endmodule

`default_nettype wire

// ==== logic/memory_stage.sv ====
// Memory stage: Wishbone classic data master, memory/writeback register and halt latch
`timescale 1ns/1ps
`default_nettype none

module memory_stage (
	input  wire logic                clk,
	input  wire logic                rst,
	input  wire wisc_pkg::word_t     result_em,
	input  wire wisc_pkg::word_t     store_data_em,
	input  wire wisc_pkg::reg_idx_t  dst_em,
	input  wire logic                reg_wr_em,
	input  wire logic                mem_rd_em,
	input  wire logic                mem_wr_em,
	input  wire logic                halt_em,
	input  wire logic                valid_em,
	input  wire wisc_pkg::word_t     wb_dat_r,
	input  wire logic                wb_ack,
	output logic                     wb_cyc,
	output logic                     wb_stb,
	output logic                     wb_we,
	output wisc_pkg::word_t          wb_adr,
	output wisc_pkg::word_t          wb_dat_w,
	output logic                     mem_busy,
	output wisc_pkg::reg_idx_t       dst_mem,
	output logic                     wr_mem,
	output logic                     wb_en,
	output wisc_pkg::reg_idx_t       wb_rd,
	output wisc_pkg::word_t          wb_data,
	output wisc_pkg::reg_idx_t       dst_wb,
	output logic                     wr_wb,
	output logic                     halted
);
	import wisc_pkg::*;

	mem_state_e state;
	logic       req;
	logic       valid_mw;
	logic       reg_wr_mw;
	reg_idx_t   rd_mw;
	word_t      data_mw;

	assign req = valid_em && (mem_rd_em || mem_wr_em) && !halted; // Nothing starts after HLT

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= idle;
		end else begin
			case (state)
				idle:     if (req) state <= bus_wait;
				bus_wait: if (wb_ack) state <= idle;
				default:  state <= idle;
			endcase
		end
	end

	// Request cycle, then hold until the ack cycle
	assign mem_busy = (state == idle) ? req : !wb_ack;

	assign wb_cyc   = (state == bus_wait);
	assign wb_stb   = wb_cyc;
	assign wb_we    = wb_cyc && mem_wr_em;
	assign wb_adr   = result_em;
	assign wb_dat_w = store_data_em;

	always_ff @(posedge clk) begin
		if (rst) begin
			valid_mw <= 1'b0;
			halted   <= 1'b0;
		end else if (!mem_busy) begin
			valid_mw <= valid_em && !halted;
			if (valid_em && halt_em) halted <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!mem_busy) begin
			rd_mw     <= dst_em;
			reg_wr_mw <= reg_wr_em;
			data_mw   <= mem_rd_em ? wb_dat_r : result_em; // Load data taken on the ack cycle
		end
	end

	assign dst_mem = dst_em;
	assign wr_mem  = valid_em && reg_wr_em;
	assign dst_wb  = rd_mw;
	assign wr_wb   = valid_mw && reg_wr_mw;
	assign wb_rd   = rd_mw;
	assign wb_data = data_mw;
	assign wb_en   = wr_wb && !mem_busy; // One write per instruction

endmodule

`default_nettype wire

// ==== logic/wisc_core.sv ====
// Top level of the five-stage core: instruction port in, Wishbone data master out
`timescale 1ns/1ps
`default_nettype none

module wisc_core (
	input  wire logic            clk,
	input  wire logic            rst,
	input  wire wisc_pkg::word_t instr_dat,
	input  wire wisc_pkg::word_t wb_dat_r,
	input  wire logic            wb_ack,
	output wisc_pkg::word_t      instr_adr,
	output logic                 wb_cyc,
	output logic                 wb_stb,
	output logic                 wb_we,
	output wisc_pkg::word_t      wb_adr,
	output wisc_pkg::word_t      wb_dat_w,
	output logic                 halted
);
	import wisc_pkg::*;

	// Front end
	logic         stall;
	logic         mem_busy;
	logic         branch_taken;
	word_t        branch_target;
	word_t        instr_fd;
	word_t        pc_fd;
	logic         valid_fd;
	reg_idx_t     rs_a;
	reg_idx_t     rs_b;
	word_t        rd_a;
	word_t        rd_b;

	// Decode/execute register
	alu_op_t      alu_op_de;
	word_t        op_a_de;
	word_t        op_b_de;
	word_t        store_data_de;
	word_t        pc_de;
	word_t        imm_de;
	reg_idx_t     dst_de;
	logic         reg_wr_de;
	logic         mem_rd_de;
	logic         mem_wr_de;
	logic         branch_de;
	logic         halt_de;
	logic         valid_de;
	branch_cond_t cond_de;

	// Execute/memory register and hazard status
	word_t        result_em;
	word_t        store_data_em;
	reg_idx_t     dst_em;
	logic         reg_wr_em;
	logic         mem_rd_em;
	logic         mem_wr_em;
	logic         halt_em;
	logic         valid_em;
	reg_idx_t     dst_ex;
	reg_idx_t     dst_mem;
	reg_idx_t     dst_wb;
	logic         wr_ex;
	logic         wr_mem;
	logic         wr_wb;

	// Register file write port
	logic         wb_en;
	reg_idx_t     wb_rd;
	word_t        wb_data;

	fetch_stage u_fetch (.*);

	decode_stage u_decode (.*);

	reg_file u_regs (
		.*,
		.wr_en   (wb_en),
		.wr_idx  (wb_rd),
		.wr_data (wb_data)
	);

	execute_stage u_execute (.*);

	memory_stage u_memory (.*);

endmodule

`default_nettype wire

// ==== testbench/wisc_checker.sv ====
// Bus watcher for the core testbench: compares Wishbone writes in order and counts errors
`timescale 1ns/1ps
`default_nettype none

module wisc_checker (
	input wire logic            clk,
	input wire logic            rst,
	input wire wisc_pkg::word_t instr_adr,
	input wire logic            wb_cyc,
	input wire logic            wb_stb,
	input wire logic            wb_we,
	input wire logic            wb_ack,
	input wire wisc_pkg::word_t wb_adr,
	input wire wisc_pkg::word_t wb_dat_w,
	input wire logic            halted
);
	import wisc_pkg::*;

	word_t exp_adr_q [$];
	word_t exp_dat_q [$];
	int    value_errors = 0;
	int    other_errors = 0;
	int    stores_seen  = 0;

	task automatic expect_store(input word_t adr, input word_t data);
		exp_adr_q.push_back(adr);
		exp_dat_q.push_back(data);
	endtask

	task automatic report_missing();
		if (exp_adr_q.size() != 0) begin
			$display("%0d expected stores never appeared on the bus", exp_adr_q.size());
			other_errors++;
		end
	endtask

	// Outputs settle after the first reset edge
	always @(negedge clk) begin
		if (rst && (wb_cyc !== 1'b0 || wb_stb !== 1'b0 || wb_we !== 1'b0 ||
			halted !== 1'b0 || instr_adr !== 16'h0000)) begin
			$display("[FAIL] %0t: bus, halted or PC not idle during reset", $time);
			value_errors++;
		end
	end

	always @(posedge clk) begin : watch
		word_t e_adr;
		word_t e_dat;
		if (!rst) begin
			if (wb_stb !== wb_cyc) begin
				$display("wb_stb and wb_cyc disagree at time %0t", $time);
				other_errors++;
			end
			if (halted && wb_cyc) begin
				$display("a bus cycle is active after halt at time %0t", $time);
				other_errors++;
			end
			if (wb_cyc && wb_stb && wb_we && wb_ack) begin // Write completes on this edge
				stores_seen++;
				if (exp_adr_q.size() == 0) begin
					$display("unexpected store of %h to %h at time %0t", wb_dat_w, wb_adr, $time);
					other_errors++;
				end else begin
					e_adr = exp_adr_q.pop_front();
					e_dat = exp_dat_q.pop_front();
					if (wb_adr !== e_adr || wb_dat_w !== e_dat) begin
						$display("[FAIL] %0t: store %0d wrote %h to %h, expected %h to %h",
							$time, stores_seen, wb_dat_w, wb_adr, e_dat, e_adr);
						value_errors++;
					end
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== testbench/tb_wisc.sv ====
// Top-level testbench: program table, instruction ROM, Wishbone data memory and the core
`timescale 1ns/1ps
`default_nettype none

module tb_wisc;
	import wisc_pkg::*;

	localparam int    MAX_CYCLES   = 3000;
	localparam int    QUIET_CYCLES = 20;
	localparam word_t HLT_WORD     = 16'hf000;

	logic  clk = 1'b0;
	logic  rst;
	word_t instr_adr;
	word_t instr_dat;
	logic  wb_cyc;
	logic  wb_stb;
	logic  wb_we;
	word_t wb_adr;
	word_t wb_dat_w;
	word_t wb_dat_r;
	logic  wb_ack;
	logic  halted;

	word_t       rom [0:255];
	word_t       dmem [0:65535];
	word_t       tbl_instr [$];
	logic        tbl_store [$];
	word_t       tbl_adr [$];
	word_t       tbl_dat [$];
	logic [31:0] rng;
	logic        active;
	int          wait_left;
	int          expected_total;
	int          cycles;

	wisc_core wisc_core_inst (
		.clk       (clk),
		.rst       (rst),
		.instr_dat (instr_dat),
		.wb_dat_r  (wb_dat_r),
		.wb_ack    (wb_ack),
		.instr_adr (instr_adr),
		.wb_cyc    (wb_cyc),
		.wb_stb    (wb_stb),
		.wb_we     (wb_we),
		.wb_adr    (wb_adr),
		.wb_dat_w  (wb_dat_w),
		.halted    (halted)
	);

	wisc_checker store_check (
		.clk       (clk),
		.rst       (rst),
		.instr_adr (instr_adr),
		.wb_cyc    (wb_cyc),
		.wb_stb    (wb_stb),
		.wb_we     (wb_we),
		.wb_ack    (wb_ack),
		.wb_adr    (wb_adr),
		.wb_dat_w  (wb_dat_w),
		.halted    (halted)
	);

	always #50 clk = ~clk;

	assign instr_dat = rom[instr_adr[7:0]]; // Same-cycle instruction port

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic add_instr(input word_t instr);
		tbl_instr.push_back(instr);
		tbl_store.push_back(1'b0);
		tbl_adr.push_back(16'h0000);
		tbl_dat.push_back(16'h0000);
	endtask

	task automatic add_store(input word_t instr, input word_t adr, input word_t data);
		tbl_instr.push_back(instr);
		tbl_store.push_back(1'b1);
		tbl_adr.push_back(adr);
		tbl_dat.push_back(data);
	endtask

	task automatic load_program();
		add_instr(16'hbf40);                   // LLB r15, base 0x0040
		add_instr(16'hb135);                   // LLB r1 = 0x0035
		add_instr(16'hb212);                   // LLB r2 = 0x0012
		add_instr(16'h0312);                   // ADD r3
		add_store(16'h93f0, 16'h0040, 16'h0047);
		add_instr(16'h1412);                   // SUB r4
		add_store(16'h94f1, 16'h0041, 16'h0023);
		add_instr(16'h2512);                   // AND r5
		add_store(16'h95f2, 16'h0042, 16'h0010);
		add_instr(16'h3612);                   // NOR r6
		add_store(16'h96f3, 16'h0043, 16'hffc8);
		add_instr(16'h4714);                   // SLL r7 by 4
		add_store(16'h97f4, 16'h0044, 16'h0350);
		add_instr(16'hb880);                   // LLB r8 = 0xff80
		add_instr(16'h5983);                   // SRL r9 by 3
		add_store(16'h99f5, 16'h0045, 16'h1ff0);
		add_instr(16'h6a83);                   // SRA r10 by 3
		add_store(16'h9af6, 16'h0046, 16'hfff0);
		add_instr(16'hbbff);                   // LLB r11
		add_instr(16'hab7f);                   // LHB r11, now 0x7fff
		add_instr(16'hbc01);                   // LLB r12 = 1
		add_instr(16'h0dbc);                   // ADD saturates, sets V
		add_store(16'h9df7, 16'h0047, 16'h7fff);
		add_instr(16'hcc01);                   // B OVFL, taken
		add_instr(16'h91ff);                   // Skipped store
		add_instr(16'hbb00);                   // LLB r11
		add_instr(16'hab80);                   // LHB r11, now 0x8000
		add_instr(16'h1dbc);                   // SUB saturates low
		add_store(16'h9dfe, 16'h003e, 16'h8000);
		add_instr(16'hb1cd);                   // LLB r1
		add_instr(16'ha1ab);                   // LHB r1, now 0xabcd
		add_store(16'h91fd, 16'h003d, 16'habcd);
		add_instr(16'hb205);                   // Dependent chain from here
		add_instr(16'h0322);
		add_instr(16'h0432);
		add_instr(16'h1543);
		add_instr(16'h4652);
		add_instr(16'h0764);
		add_store(16'h97fc, 16'h003c, 16'h0023);
		add_instr(16'h88f0);                   // LW r8 from 0x0040
		add_instr(16'h0987);                   // ADD on loaded value
		add_store(16'h99fb, 16'h003b, 16'h006a);
		add_instr(16'h8afd);                   // LW r10 from 0x003d
		add_store(16'h9afa, 16'h003a, 16'habcd);
		add_instr(16'hc201);                   // B EQ, not taken
		add_store(16'h91f9, 16'h0039, 16'habcd);
		add_instr(16'hc001);                   // B NEQ, taken
		add_instr(16'h92f8);                   // Skipped store
		add_instr(16'h1323);                   // SUB r3 = 0xfffb, sets N
		add_instr(16'hc601);                   // B LT, taken
		add_instr(16'h93f8);                   // Skipped store
		add_instr(16'hc401);                   // B GT, not taken
		add_store(16'h93f8, 16'h0038, 16'hfffb);
		add_instr(16'h242b);                   // AND gives zero, N kept
		add_instr(16'hc202);                   // B EQ over two stores
		add_instr(16'h92f7);
		add_instr(16'h92f6);
		add_instr(16'hc601);                   // B LT, taken since branches keep N
		add_instr(16'h92f6);                   // Skipped store
		add_instr(16'hc801);                   // B GTE, taken on Z
		add_instr(16'h92f5);
		add_instr(16'hce01);                   // Unconditional
		add_instr(16'h92f4);
		add_instr(16'h0533);                   // ADD r5 = 0xfff6
		add_instr(16'hc801);                   // B GTE, not taken
		add_store(16'h95f4, 16'h0044, 16'hfff6);
		add_instr(16'hca01);                   // B LTE, taken
		add_instr(16'h95f3);                   // Skipped store
		add_instr(16'hb603);                   // Loop count 3
		add_instr(16'hb701);
		add_instr(16'hb800);
		add_instr(16'h0886);                   // Sum 3 + 2 + 1
		add_instr(16'h1667);
		add_instr(16'hc1fd);                   // B NEQ back by 3
		add_store(16'h98f2, 16'h0042, 16'h0006);
		add_instr(HLT_WORD);
		add_instr(16'h91f0);                   // Store that must not run after halt
	endtask

	// Data memory slave, 0 to 3 wait cycles before ack
	always begin : data_slave
		@(posedge clk);
		#5;
		if (rst) begin
			wb_ack = 1'b0;
			active = 1'b0;
		end else if (wb_ack) begin
			wb_ack = 1'b0; // Cycle ended on the last edge
			active = 1'b0;
		end else if (wb_cyc && wb_stb) begin
			if (!active) begin
				active    = 1'b1;
				rng       = xorshift32(rng);
				wait_left = int'(rng[1:0]);
			end
			if (wait_left == 0) begin
				if (wb_we) begin
					dmem[wb_adr] = wb_dat_w;
				end else begin
					wb_dat_r = dmem[wb_adr];
				end
				wb_ack = 1'b1;
			end else begin
				wait_left--;
			end
		end
	end

	initial begin : run
		rst            = 1'b1;
		wb_ack         = 1'b0;
		wb_dat_r       = '0;
		active         = 1'b0;
		wait_left      = 0;
		rng            = 32'h28f6;
		expected_total = 0;
		cycles         = 0;
		for (int i = 0; i < 65536; i++) begin
			dmem[i] = 16'(i) ^ 16'h5aa5; // Address-dependent fill
		end
		for (int i = 0; i < 256; i++) begin
			rom[i] = HLT_WORD;
		end
		load_program();
		for (int i = 0; i < tbl_instr.size(); i++) begin
			rom[i] = tbl_instr[i];
			if (tbl_store[i]) begin
				store_check.expect_store(tbl_adr[i], tbl_dat[i]);
				expected_total++;
			end
		end

		repeat (10) @(posedge clk);
		#5;
		rst = 1'b0;

		while (halted !== 1'b1 && cycles < MAX_CYCLES) begin
			@(posedge clk);
			cycles++;
		end

		if (halted !== 1'b1) begin
			$display("timeout: halted did not rise within %0d cycles", MAX_CYCLES);
			$display("test failed");
		end else begin
			// Window to catch any bus cycle after halt
			for (int i = 0; i < QUIET_CYCLES; i++) begin
				@(posedge clk);
			end
			store_check.report_missing();
			$display("stores seen %0d of %0d, value errors %0d, other errors %0d",
				store_check.stores_seen, expected_total,
				store_check.value_errors, store_check.other_errors);
			if (store_check.value_errors == 0 && store_check.other_errors == 0 &&
				store_check.stores_seen == expected_total) begin
				$display("test passed");
			end else begin
				$display("test failed");
			end
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+include
logic/wisc_pkg.sv
logic/fetch_stage.sv
logic/reg_file.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/memory_stage.sv
logic/wisc_core.sv
testbench/wisc_checker.sv
testbench/tb_wisc.sv

// ==== Bender.yml ====
package:
  name: wisc_core

sources:
  - include_dirs:
      - include
    files:
      - logic/wisc_pkg.sv
      - logic/fetch_stage.sv
      - logic/reg_file.sv
      - logic/decode_stage.sv
      - logic/execute_stage.sv
      - logic/memory_stage.sv
      - logic/wisc_core.sv
  - target: test
    files:
      - testbench/wisc_checker.sv
      - testbench/tb_wisc.sv
